// ==== verilog/gic_cfg.svh ====
// Sizes only; GIC_RDQ_DEPTH must be a power of two, word counts must fit GIC_GLB_AW bits
`ifndef GIC_CFG_SVH
`define GIC_CFG_SVH

// ==========================================================================
// Off-chip port
// ==========================================================================

// Beat data width, also the buffer word width
`define GIC_PORT_W 64

// DRAM byte address carried in the command beat
`define GIC_DRAM_AW 32

// ==========================================================================
// Global buffer
// ==========================================================================

// 8 bits gives 256 words
`define GIC_GLB_AW 8

// Read-data queue entries, equals the number of read credits
`define GIC_RDQ_DEPTH 4

`endif

// ==== verilog/gicPkg.sv ====
// Shared types for the controller; sizes come from gic_cfg.svh, count of zero is illegal
`include "gic_cfg.svh"

package gicPkg;

    // ======================================================================
    // Plain vectors
    // ======================================================================

    // One off-chip beat or one buffer word
    typedef logic [`GIC_PORT_W-1:0] portDatT;
    // Buffer word address
    typedef logic [`GIC_GLB_AW-1:0] glbAddrT;
    // Word count, 1 to 255
    typedef logic [`GIC_GLB_AW-1:0] wordCntT;
    // Off-chip address
    typedef logic [`GIC_DRAM_AW-1:0] dramAddrT;

    // ======================================================================
    // Enums
    // ======================================================================

    // Transfer direction, bit 0 of the command word
    typedef enum logic {
        dirIn  = 1'b0,
        dirOut = 1'b1
    } gicDirT;

    // Controller FSM
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stCmd  = 2'd1,
        stIn   = 2'd2,
        stOut  = 2'd3
    } gicStateT;

    // ======================================================================
    // Structs
    // ======================================================================

    // One transfer description, 49 bits
    typedef struct packed {
        glbAddrT  glbBase;
        dramAddrT dramBase;
        wordCntT  num;
        gicDirT   dir;
    } gicCfgT;

    // Command word in dat[40:0]: num at [40:33], dramBase at [32:1], dir at [0]
    // Upper bits of a command beat are zero
    typedef struct packed {
        portDatT dat;
        logic    last;
    } gicBeatT;

endpackage

// ==== verilog/globalInputCtrl.sv ====
// Takes a config only while idle; num must be nonzero; buffer address wraps at 256 words
`timescale 1ns/1ns

module globalInputCtrl
    import gicPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Configuration
    input  logic     cfgVld,
    output logic     cfgRdy,
    input  gicCfgT   cfg,
    // Off-chip out, command then read data
    output logic     cmdVld,
    output logic     itfOutVld,
    output gicBeatT  itfOut,
    input  logic     itfOutRdy,
    // Off-chip in
    input  logic     itfInVld,
    input  gicBeatT  itfIn,
    output logic     itfInRdy,
    // Buffer write
    output logic     glbWrEn,
    output glbAddrT  glbWrAddr,
    output portDatT  glbWrDat,
    // Buffer read
    output logic     glbRdAddrVld,
    output glbAddrT  glbRdAddr,
    input  logic     glbRdAddrRdy,
    input  logic     glbRdDatVld,
    input  portDatT  glbRdDat,
    output logic     glbRdDatRdy
);

    // Command field widths
    localparam int CmdW = $bits(wordCntT) + $bits(dramAddrT) + 1;

    gicStateT state;
    gicStateT stateNxt;
    gicCfgT   cfgReg;
    wordCntT  issueCnt;
    wordCntT  sentCnt;
    wordCntT  lastIdx;
    portDatT  cmdDat;
    glbAddrT  wordAddr;

    logic cfgAcc;
    logic cmdAcc;
    logic inAcc;
    logic rdAddrAcc;
    logic rdDatAcc;
    logic inDone;
    logic outDone;

    // ======================================================================
    // Handshakes
    // ======================================================================

    assign cfgRdy    = (state == stIdle);
    assign cfgAcc    = cfgVld & cfgRdy;
    assign cmdAcc    = (state == stCmd) & itfOutRdy;
    assign inAcc     = itfInVld & itfInRdy;
    assign rdAddrAcc = glbRdAddrVld & glbRdAddrRdy;
    assign rdDatAcc  = glbRdDatVld & glbRdDatRdy;

    // Index of the final word
    assign lastIdx = cfgReg.num - 1'b1;

    // Input ends on count or on an early last
    assign inDone  = inAcc & ((issueCnt == lastIdx) | itfIn.last);
    // Output ends when the final word leaves
    assign outDone = rdDatAcc & (sentCnt == lastIdx);

    // ======================================================================
    // Transfer FSM
    // ======================================================================

    always_comb begin
        stateNxt = state;
        case (state)
            stIdle: begin
                if (cfgAcc) begin
                    stateNxt = stCmd;
                end
            end
            stCmd: begin
                // Direction picked once the command leaves
                if (cmdAcc) begin
                    stateNxt = (cfgReg.dir == dirOut) ? stOut : stIn;
                end
            end
            stIn: begin
                if (inDone) begin
                    stateNxt = stIdle;
                end
            end
            stOut: begin
                if (outDone) begin
                    stateNxt = stIdle;
                end
            end
            default: stateNxt = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= stIdle;
        end else begin
            state <= stateNxt;
        end
    end

    // Config held for the whole transfer
    always_ff @(posedge clk) begin
        if (cfgAcc) begin
            cfgReg <= cfg;
        end
    end

    // ======================================================================
    // Counters
    // ======================================================================

    // Words written on input, addresses issued on output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issueCnt <= '0;
        end else if (cfgAcc) begin
            issueCnt <= '0;
        end else if (inAcc | rdAddrAcc) begin
            issueCnt <= issueCnt + 1'b1;
        end
    end

    // Words handed off-chip
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sentCnt <= '0;
        end else if (cfgAcc) begin
            sentCnt <= '0;
        end else if (rdDatAcc) begin
            sentCnt <= sentCnt + 1'b1;
        end
    end

    // Base plus counter, wraps inside the buffer
    assign wordAddr = cfgReg.glbBase + issueCnt;

    // ======================================================================
    // Command beat and output steering
    // ======================================================================

    always_comb begin
        cmdDat = '0;
        cmdDat[CmdW-1:0] = {cfgReg.num, cfgReg.dramBase, cfgReg.dir};
    end

    assign cmdVld    = (state == stCmd);
    // Command first, then queue head
    assign itfOutVld = cmdVld | ((state == stOut) & glbRdDatVld);
    assign itfOut.dat  = cmdVld ? cmdDat : glbRdDat;
    assign itfOut.last = (state == stOut) & (sentCnt == lastIdx);

    // ======================================================================
    // Buffer side
    // ======================================================================

    // Writes never stall
    assign itfInRdy  = (state == stIn);
    assign glbWrEn   = inAcc;
    assign glbWrAddr = wordAddr;
    assign glbWrDat  = itfIn.dat;

    // Stop issuing once num addresses are out
    assign glbRdAddrVld = (state == stOut) & (issueCnt < cfgReg.num);
    assign glbRdAddr    = wordAddr;
    assign glbRdDatRdy  = (state == stOut) & itfOutRdy;

    // ======================================================================
    // Assertions
    // ======================================================================

    // Zero-length transfer never enters the FSM
    property pNoZeroNum;
        @(posedge clk) disable iff (!rst_n)
        cfgAcc |-> (cfg.num != '0);
    endproperty
    aNoZeroNum: assert property (pNoZeroNum);

    // Stalled beat keeps its payload
    property pOutStable;
        @(posedge clk) disable iff (!rst_n)
        (itfOutVld && !itfOutRdy) |=> $stable(itfOut);
    endproperty
    aOutStable: assert property (pOutStable);

endmodule

// ==== verilog/globalBuffer.sv ====
// 256-word buffer, one-cycle read into a credit-counted queue; write and read same word undefined order
`timescale 1ns/1ns
`include "gic_cfg.svh"

module globalBuffer
    import gicPkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Write port
    input  logic    wrEn,
    input  glbAddrT wrAddr,
    input  portDatT wrDat,
    // Read address
    input  logic    rdAddrVld,
    input  glbAddrT rdAddr,
    output logic    rdAddrRdy,
    // Read data
    output logic    rdDatVld,
    output portDatT rdDat,
    input  logic    rdDatRdy
);

    localparam int Words = 1 << `GIC_GLB_AW;
    localparam int QDepth = `GIC_RDQ_DEPTH;
    localparam int PtrW = $clog2(QDepth);
    localparam int CntW = $clog2(QDepth + 1);

    portDatT mem [Words];
    portDatT rdReg;
    logic    rdPend;

    portDatT           queue [QDepth];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [CntW-1:0]   qCnt;
    logic [CntW-1:0]   credits;

    logic addrAcc;
    logic push;
    logic pop;
    logic qFull;

    // ======================================================================
    // Memory array
    // ======================================================================

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrDat;
        end
    end

    assign addrAcc = rdAddrVld & rdAddrRdy;

    // Registered read, data lands one cycle later
    always_ff @(posedge clk) begin
        if (addrAcc) begin
            rdReg <= mem[rdAddr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPend <= 1'b0;
        end else begin
            rdPend <= addrAcc;
        end
    end

    // ======================================================================
    // Read-data queue
    // ======================================================================

    assign push     = rdPend;
    assign pop      = rdDatVld & rdDatRdy;
    assign qFull    = (qCnt == CntW'(QDepth));
    assign rdDatVld = (qCnt != '0);
    assign rdDat    = queue[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wrPtr] <= rdReg;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            qCnt  <= '0;
        end else begin
            // Pointers wrap with a power-of-two depth
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            qCnt <= qCnt + CntW'(push) - CntW'(pop);
        end
    end

    // ======================================================================
    // Credits
    // ======================================================================

    // One credit per entry, taken at address accept, returned at pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CntW'(QDepth);
        end else begin
            credits <= credits - CntW'(addrAcc) + CntW'(pop);
        end
    end

    assign rdAddrRdy = (credits != '0);

    // ======================================================================
    // Assertions
    // ======================================================================

    aNoOverflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !qFull);

    // Credits plus queued plus in-flight always cover the depth
    aCreditSum: assert property (@(posedge clk) disable iff (!rst_n)
        (credits <= CntW'(QDepth)) &&
        (32'(credits) + 32'(qCnt) + 32'(rdPend) == QDepth));

endmodule

// ==== verilog/gicTop.sv ====
// Controller plus global buffer; config and off-chip ports only, buffer not reachable from outside
`timescale 1ns/1ns

module gicTop
    import gicPkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Configuration
    input  logic    cfgVld,
    output logic    cfgRdy,
    input  gicCfgT  cfg,
    // Off-chip out
    output logic    cmdVld,
    output logic    itfOutVld,
    output gicBeatT itfOut,
    input  logic    itfOutRdy,
    // Off-chip in
    input  logic    itfInVld,
    input  gicBeatT itfIn,
    output logic    itfInRdy
);

    // ======================================================================
    // Controller to buffer
    // ======================================================================

    logic    glbWrEn;
    glbAddrT glbWrAddr;
    portDatT glbWrDat;
    logic    glbRdAddrVld;
    glbAddrT glbRdAddr;
    logic    glbRdAddrRdy;
    logic    glbRdDatVld;
    portDatT glbRdDat;
    logic    glbRdDatRdy;

    globalInputCtrl globalInputCtrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfgVld       (cfgVld),
        .cfgRdy       (cfgRdy),
        .cfg          (cfg),
        .cmdVld       (cmdVld),
        .itfOutVld    (itfOutVld),
        .itfOut       (itfOut),
        .itfOutRdy    (itfOutRdy),
        .itfInVld     (itfInVld),
        .itfIn        (itfIn),
        .itfInRdy     (itfInRdy),
        .glbWrEn      (glbWrEn),
        .glbWrAddr    (glbWrAddr),
        .glbWrDat     (glbWrDat),
        .glbRdAddrVld (glbRdAddrVld),
        .glbRdAddr    (glbRdAddr),
        .glbRdAddrRdy (glbRdAddrRdy),
        .glbRdDatVld  (glbRdDatVld),
        .glbRdDat     (glbRdDat),
        .glbRdDatRdy  (glbRdDatRdy)
    );

    // Buffer with its own read queue
    globalBuffer globalBuffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wrEn      (glbWrEn),
        .wrAddr    (glbWrAddr),
        .wrDat     (glbWrDat),
        .rdAddrVld (glbRdAddrVld),
        .rdAddr    (glbRdAddr),
        .rdAddrRdy (glbRdAddrRdy),
        .rdDatVld  (glbRdDatVld),
        .rdDat     (glbRdDat),
        .rdDatRdy  (glbRdDatRdy)
    );

endmodule

// ==== verif/gicTbTable.svh ====
// Rows run in order and depend on earlier rows; output rows must only read words written before
`ifndef GIC_TB_TABLE_SVH
`define GIC_TB_TABLE_SVH

// Columns: dir, glbBase, dramBase, num, early-last index (-1 none), seed offset, stall mask
// Stall mask is ANDed with random low bits, ready only when the result is zero

localparam int NumRows = 11;

xferRowT rows [NumRows] = '{
    // Plain write then read back of the same block
    '{dirIn,  8'h10, 32'h8000_0000, 8'd16, -1, 32'h0000_0001, 4'h0},
    '{dirOut, 8'h10, 32'h8000_1000, 8'd16, -1, 32'h0000_0002, 4'h0},
    // Full block, then early last overwrites the first 10 words only
    '{dirIn,  8'h40, 32'h1234_5678, 8'd32, -1, 32'h0000_0003, 4'h0},
    '{dirIn,  8'h40, 32'h1234_5678, 8'd32,  9, 32'h0000_0004, 4'h0},
    // Old contents must show past the early last, with back-pressure
    '{dirOut, 8'h40, 32'hdead_beef, 8'd32, -1, 32'h0000_0005, 4'h3},
    // Shifted base over the same range
    '{dirOut, 8'h48, 32'h0000_0040, 8'd24, -1, 32'h0000_0006, 4'h1},
    // Block that wraps past the top of the buffer
    '{dirIn,  8'hf0, 32'hffff_fff0, 8'd24, -1, 32'h0000_0007, 4'h0},
    '{dirOut, 8'hf8, 32'h0000_0008, 8'd16, -1, 32'h0000_0008, 4'h7},
    // Single-word transfers
    '{dirOut, 8'h12, 32'h0abc_def0, 8'd1,  -1, 32'h0000_0009, 4'h0},
    '{dirIn,  8'h80, 32'h5555_aaaa, 8'd8,   0, 32'h0000_000a, 4'h0},
    '{dirOut, 8'h80, 32'haaaa_5555, 8'd1,  -1, 32'h0000_000b, 4'h1}
};

`endif

// ==== verif/gicTb.sv ====
// Self-checking; assumes table rows only read buffer words that earlier rows wrote
`timescale 1ns/1ns
`include "gic_cfg.svh"

module gicTb
    import gicPkg::*;
();

    localparam int ResetCycles = 10;
    localparam int RowCycles = 400;
    localparam logic [31:0] Seed = 32'h0ff5a20d;

    // One table row
    typedef struct packed {
        gicDirT      dir;
        glbAddrT     glbBase;
        dramAddrT    dramBase;
        wordCntT     num;
        int          earlyLast;
        logic [31:0] seedOfs;
        logic [3:0]  stallMask;
    } xferRowT;

    `include "gicTbTable.svh"

    logic    clk = 1'b0;
    logic    rst_n;
    logic    cfgVld;
    logic    cfgRdy;
    gicCfgT  cfg;
    logic    cmdVld;
    logic    itfOutVld;
    gicBeatT itfOut;
    logic    itfOutRdy;
    logic    itfInVld;
    gicBeatT itfIn;
    logic    itfInRdy;

    // Reference copy of the buffer, built from accepted input beats
    portDatT     shadow [1 << `GIC_GLB_AW];
    logic [31:0] rngState;

    always #10 clk = ~clk;

    gicTop gicTop_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfgVld    (cfgVld),
        .cfgRdy    (cfgRdy),
        .cfg       (cfg),
        .cmdVld    (cmdVld),
        .itfOutVld (itfOutVld),
        .itfOut    (itfOut),
        .itfOutRdy (itfOutRdy),
        .itfInVld  (itfInVld),
        .itfIn     (itfIn),
        .itfInRdy  (itfInRdy)
    );

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Two draws per 64-bit word
    task automatic nextWord(output portDatT w);
        rngState = xorshift(rngState);
        w[63:32] = rngState;
        rngState = xorshift(rngState);
        w[31:0] = rngState;
    endtask

    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // ======================================================================
    // One transfer, cycle by cycle: drive at +2 ns, sample at falling edge
    // ======================================================================

    task automatic runRow(input xferRowT r);
        portDatT expCmd;
        portDatT inWord;
        glbAddrT addr;
        int      idx;
        int      cyc;
        int      cmdCnt;
        bit      done;

        rngState = Seed ^ r.seedOfs;
        // num, dramBase, dir packed from the top of the low 41 bits
        expCmd = (64'(r.num) << 33) | (64'(r.dramBase) << 1) | 64'(r.dir);
        nextWord(inWord);
        idx = 0;
        cyc = 0;
        cmdCnt = 0;
        done = 1'b0;

        @(posedge clk);
        #2;
        cfgVld = 1'b1;
        cfg = '{glbBase: r.glbBase, dramBase: r.dramBase, num: r.num, dir: r.dir};
        @(negedge clk);
        checkVal("cfgRdy", 64'(cfgRdy), 64'd1);
        @(posedge clk);
        #2;
        cfgVld = 1'b0;
        cfg = '0;

        while (!done) begin
            rngState = xorshift(rngState);
            itfOutRdy = ((rngState[3:0] & r.stallMask) == 4'd0);
            // Source holds each word until taken
            itfInVld = (r.dir == dirIn);
            itfIn.dat = inWord;
            itfIn.last = (idx == r.earlyLast);
            @(negedge clk);
            checkVal("cfgRdy", 64'(cfgRdy), 64'd0);
            if (cyc == 0) begin
                checkVal("cmdVld", 64'(cmdVld), 64'd1);
            end
            if (cmdVld) begin
                checkVal("itfOutVld", 64'(itfOutVld), 64'd1);
                if (itfOutRdy) begin
                    checkVal("itfOut.dat", itfOut.dat, expCmd);
                    cmdCnt++;
                end
            end else if (itfOutVld && itfOutRdy) begin
                // Data only after the single command
                checkVal("cmdCount", 64'(cmdCnt), 64'd1);
                addr = r.glbBase + glbAddrT'(idx);
                checkVal("itfOut.dat", itfOut.dat, shadow[addr]);
                checkVal("itfOut.last", 64'(itfOut.last), 64'(idx == int'(r.num) - 1));
                idx++;
                done = (idx == int'(r.num));
            end
            if (itfInVld && itfInRdy) begin
                addr = r.glbBase + glbAddrT'(idx);
                shadow[addr] = inWord;
                idx++;
                done = itfIn.last || (idx == int'(r.num));
                nextWord(inWord);
            end
            cyc++;
            @(posedge clk);
            #2;
        end

        // Back to idle the cycle after the final beat, nothing extra on the port
        itfInVld = 1'b0;
        itfIn = '0;
        @(negedge clk);
        checkVal("cfgRdy", 64'(cfgRdy), 64'd1);
        checkVal("itfOutVld", 64'(itfOutVld), 64'd0);
        checkVal("itfInRdy", 64'(itfInRdy), 64'd0);
        checkVal("cmdCount", 64'(cmdCnt), 64'd1);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        rst_n = 1'b0;
        cfgVld = 1'b0;
        cfg = '0;
        itfOutRdy = 1'b0;
        itfInVld = 1'b0;
        itfIn = '0;
        repeat (ResetCycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        checkVal("cfgRdy", 64'(cfgRdy), 64'd1);
        checkVal("cmdVld", 64'(cmdVld), 64'd0);
        checkVal("itfOutVld", 64'(itfOutVld), 64'd0);
        checkVal("itfInRdy", 64'(itfInRdy), 64'd0);
        for (int i = 0; i < NumRows; i++) begin
            runRow(rows[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

    // Budget per row plus reset
    initial begin
        repeat (ResetCycles + NumRows * RowCycles) @(posedge clk);
        $display("Watchdog expired: transfers did not finish in %0d cycles, DUT looks hung",
                 ResetCycles + NumRows * RowCycles);
        $display("TEST FAILED");
        $fatal(1, "Stopped by watchdog");
    end

endmodule

// ==== project.f ====
+incdir+verilog
+incdir+verif
verilog/gicPkg.sv
verilog/globalInputCtrl.sv
verilog/globalBuffer.sv
verilog/gicTop.sv
verif/gicTb.sv

// ==== Makefile ====
# Verilator build and run for the global input controller testbench
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= gicTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j $(JOBS)

# Every source and header, so the binary is rebuilt only when one changes
SRCS := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv verif/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
